// ==== dv/controlCases.txt ====
# kind followed by hex operands, one case per line
# hold en dly time | raz en dly mode | force bit mode en | tstamp | dtrig en | done mask ends | static sel rstb pa pd padc pdac
static 1 0 0 0 0 0
hold 1 3 5
hold 1 0 1
hold 0 2 4
hold 1 5 a
raz 1 2 0
raz 1 0 1
raz 1 f 2
raz 1 5 3
raz 0 3 1
force 0 0 0
force 3 2 1
force 1 3 0
tstamp
dtrig 1
dtrig 0
done f f
done 5 7
done 6 2
done 6 4
done 0 f
done 3 0
static 0 5 1 8 0 2

// ==== dv/microrocCommonControlTb.sv ====
module microrocCommonControlTb;
  import microrocCtrlPkg::*;

  localparam int chainCount = 4;
  localparam int casePeriod = 600;  // Watchdog budget per case

  logic                    Clk;
  logic                    reset;
  logic                    TriggerIn;
  logic                    TriggerOr;
  logic                    HoldEnable;
  logic [HOLD_DELAY_W-1:0] HoldDelay;
  logic [HOLD_TIME_W-1:0]  HoldTime;
  logic                    HoldSignal;
  logic                    ExternalRazSignalEnable;
  logic [RAZ_DELAY_W-1:0]  ExternalRazDelayTime;
  razMode_t                RazMode;
  logic [chainCount-1:0]   ForceExternalRaz;
  logic                    RazChn;
  logic                    SlowControlOrReadScopeSelect;
  logic                    Select;
  logic [chainCount-1:0]   ResetB;
  logic                    AsicResetB;
  logic                    ResetTimeStamp;
  logic                    DataTrigger;
  logic                    DataTriggerEnable;
  logic                    rstCounterB;
  logic                    TrigExt;
  logic [chainCount-1:0]   OnceEnd;
  logic [chainCount-1:0]   EndReadoutParameter;
  logic                    RamReadoutDone;
  logic [chainCount-1:0]   PwrOnA;
  logic [chainCount-1:0]   PwrOnD;
  logic [chainCount-1:0]   PwrOnAdc;
  logic [chainCount-1:0]   PwrOnDac;
  logic                    PwrOnAOut;
  logic                    PwrOnDOut;
  logic                    PwrOnAdcOut;
  logic                    PwrOnDacOut;

  string                 caseKinds[$];
  logic [5:0][31:0]      caseOps[$];
  logic                  casesLoaded;
  logic [chainCount-1:0] modelFlags;  // Expected sticky end flags

  microrocCommonControl #(.chainCount(chainCount)) u_microrocCommonControl (.*);

  initial Clk = 1'b0;
  always #4 Clk = ~Clk;

  //////////////////////////////////////////////////////////////////////
  // Watchdog
  //////////////////////////////////////////////////////////////////////
  initial begin
    wait (casesLoaded);
    #(caseKinds.size() * casePeriod);
    $display("Watchdog expired before all cases finished");
    $display("tests failed");
    $fatal(1, "Simulation timeout");
  end

  //////////////////////////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////////////////////////
  task automatic checkBit(input string name, input logic expVal, input logic actVal);
    if (actVal !== expVal) begin
      $display("[ERROR] t=%0t %s expected %b actual %b", $time, name, expVal, actVal);
      $display("tests failed");
      $fatal(1, "Bit mismatch");
    end
  endtask

  task automatic checkWidth(input string name, input logic [HOLD_TIME_W-1:0] expVal,
                            input logic [HOLD_TIME_W-1:0] actVal);
    if (actVal !== expVal) begin
      $display("[ERROR] t=%0t %s expected %0d actual %0d", $time, name, expVal, actVal);
      $display("tests failed");
      $fatal(1, "Count mismatch");
    end
  endtask

  // Watched output by index, counter reset flipped to active high
  function automatic logic probe(input int sel);
    case (sel)
      0:       return HoldSignal;
      1:       return RazChn;
      2:       return ~rstCounterB;
      3:       return TrigExt;
      default: return RamReadoutDone;
    endcase
  endfunction

  // True when every masked chain has ended and the mask is not empty
  function automatic logic maskedAllEnded(input logic [chainCount-1:0] flags,
                                          input logic [chainCount-1:0] mask);
    logic anyMasked;
    logic allEnded;
    anyMasked = 1'b0;
    allEnded  = 1'b1;
    for (int i = 0; i < chainCount; i++) begin
      if (mask[i]) begin
        anyMasked = 1'b1;
        if (!flags[i]) allEnded = 1'b0;
      end
    end
    return anyMasked && allEnded;
  endfunction

  task automatic releaseTriggers();
    TriggerIn        = 1'b0;
    TriggerOr        = 1'b0;
    ForceExternalRaz = '0;
    ResetTimeStamp   = 1'b0;
    DataTrigger      = 1'b0;
    OnceEnd          = '0;
  endtask

  // Rise is counted in edges after the first edge that follows the call
  task automatic measurePulse(input int sel, input int maxWait, output int rise,
                              output int width);
    int n;
    rise  = -1;
    width = 0;
    n     = 0;
    while (rise < 0 && n < maxWait) begin
      @(negedge Clk);
      n++;
      if (n == 1) releaseTriggers();  // One-cycle request
      if (probe(sel)) rise = n - 1;
    end
    while (rise >= 0 && probe(sel) && width < 1000) begin
      width++;
      @(negedge Clk);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Case file
  //////////////////////////////////////////////////////////////////////
  task automatic loadCases();
    int          fd;
    string       line;
    string       kind;
    logic [31:0] o0, o1, o2, o3, o4, o5;
    fd = $fopen("dv/controlCases.txt", "r");
    if (fd == 0) begin
      $display("Could not open the case file dv/controlCases.txt");
      $display("tests failed");
      $fatal(1, "Missing case file");
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 1 && line.substr(0, 0) != "#") begin
        {o0, o1, o2, o3, o4, o5} = '0;
        void'($sscanf(line, "%s %h %h %h %h %h %h", kind, o0, o1, o2, o3, o4, o5));
        caseKinds.push_back(kind);
        caseOps.push_back({o5, o4, o3, o2, o1, o0});  // Index 0 is first operand
      end
    end
    $fclose(fd);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Case execution
  //////////////////////////////////////////////////////////////////////
  task automatic runCase(input string kind, input logic [5:0][31:0] op);
    int       rise;
    int       width;
    int       rise2;
    int       width2;
    int       dly;
    razMode_t mode;
    logic     expDone;
    logic [chainCount-1:0] oneHot;
    dly  = int'(op[1]);
    mode = razMode_t'(op[2][1:0]);
    if (kind == "hold") begin
      HoldEnable              = op[0][0];
      HoldDelay               = op[1][HOLD_DELAY_W-1:0];
      HoldTime                = op[2][HOLD_TIME_W-1:0];
      RazMode                 = razMode_t'(2'($urandom_range(3, 0)));
      ExternalRazSignalEnable = 1'($urandom_range(1, 0));
      TriggerIn               = 1'b1;
      measurePulse(0, dly + int'(op[2]) + 8, rise, width);
      checkBit("HoldSignal rose", op[0][0], rise >= 0);
      if (op[0][0]) begin
        checkWidth("HoldSignal delay", HOLD_TIME_W'(dly + 1), HOLD_TIME_W'(rise));
        checkWidth("HoldSignal width", op[2][HOLD_TIME_W-1:0], HOLD_TIME_W'(width));
        // Strobe sampled at the next edge, RAZ one edge after
        measurePulse(1, 6, rise2, width2);
        checkWidth("RazChn after hold", HOLD_TIME_W'(1), HOLD_TIME_W'(rise2));
        checkWidth("RazChn width", HOLD_TIME_W'(RAZ_WIDTH_TABLE[RazMode]),
                   HOLD_TIME_W'(width2));
      end else begin
        checkBit("RazChn", 1'b0, RazChn);
      end
    end else if (kind == "raz") begin
      ExternalRazSignalEnable = op[0][0];
      ExternalRazDelayTime    = op[1][RAZ_DELAY_W-1:0];
      RazMode                 = mode;
      HoldEnable              = 1'($urandom_range(1, 0));
      TriggerOr               = 1'b1;
      measurePulse(1, dly + 6, rise, width);
      checkBit("RazChn rose", op[0][0], rise >= 0);
      if (op[0][0]) begin
        checkWidth("RazChn delay", HOLD_TIME_W'(dly + 1), HOLD_TIME_W'(rise));
        checkWidth("RazChn width", HOLD_TIME_W'(RAZ_WIDTH_TABLE[mode]), HOLD_TIME_W'(width));
      end
    end else if (kind == "force") begin
      oneHot                  = chainCount'(1) << op[0][1:0];
      RazMode                 = razMode_t'(op[1][1:0]);
      ExternalRazSignalEnable = op[2][0];  // Force ignores it
      ForceExternalRaz        = oneHot;
      measurePulse(1, 6, rise, width);
      checkWidth("RazChn force delay", HOLD_TIME_W'(1), HOLD_TIME_W'(rise));
      checkWidth("RazChn width", HOLD_TIME_W'(RAZ_WIDTH_TABLE[RazMode]), HOLD_TIME_W'(width));
    end else if (kind == "tstamp") begin
      DataTriggerEnable = 1'($urandom_range(1, 0));
      ResetTimeStamp    = 1'b1;
      measurePulse(2, 6, rise, width);
      checkWidth("rstCounterB delay", HOLD_TIME_W'(1), HOLD_TIME_W'(rise));
      checkWidth("rstCounterB low width", HOLD_TIME_W'(TS_RESET_CYCLES), HOLD_TIME_W'(width));
    end else if (kind == "dtrig") begin
      DataTriggerEnable = op[0][0];
      DataTrigger       = 1'b1;
      measurePulse(3, 6, rise, width);
      checkBit("TrigExt rose", op[0][0], rise >= 0);
      if (op[0][0]) begin
        checkWidth("TrigExt delay", HOLD_TIME_W'(1), HOLD_TIME_W'(rise));
        checkWidth("TrigExt width", HOLD_TIME_W'(1), HOLD_TIME_W'(width));
      end
    end else if (kind == "done") begin
      // New mask may already be met by leftover flags
      EndReadoutParameter = op[0][chainCount-1:0];
      expDone = maskedAllEnded(modelFlags, EndReadoutParameter);
      @(negedge Clk);
      checkBit("RamReadoutDone on mask", expDone, RamReadoutDone);
      if (expDone) modelFlags = '0;
      for (int i = 0; i < chainCount; i++) begin
        if (op[1][i]) begin
          oneHot  = chainCount'(1) << i;
          OnceEnd = oneHot;
          @(negedge Clk);
          OnceEnd = '0;
          checkBit("RamReadoutDone early", 1'b0, RamReadoutDone);
          modelFlags = modelFlags | oneHot;
          expDone = maskedAllEnded(modelFlags, EndReadoutParameter);
          @(negedge Clk);
          checkBit("RamReadoutDone", expDone, RamReadoutDone);
          if (expDone) modelFlags = '0;  // Fresh round
        end
      end
      @(negedge Clk);
      checkBit("RamReadoutDone single", 1'b0, RamReadoutDone);
    end else if (kind == "static") begin
      SlowControlOrReadScopeSelect = op[0][0];
      ResetB   = op[1][chainCount-1:0];
      PwrOnA   = op[2][chainCount-1:0];
      PwrOnD   = op[3][chainCount-1:0];
      PwrOnAdc = op[4][chainCount-1:0];
      PwrOnDac = op[5][chainCount-1:0];
      #1;
      checkBit("Select", !op[0][0], Select);       // Inverted pin
      checkBit("AsicResetB", op[1][chainCount-1:0] != '0, AsicResetB);
      checkBit("PwrOnAOut", op[2][chainCount-1:0] != '0, PwrOnAOut);
      checkBit("PwrOnDOut", op[3][chainCount-1:0] != '0, PwrOnDOut);
      checkBit("PwrOnAdcOut", op[4][chainCount-1:0] != '0, PwrOnAdcOut);
      checkBit("PwrOnDacOut", op[5][chainCount-1:0] != '0, PwrOnDacOut);
    end else begin
      $display("Unknown case kind %s in the case file", kind);
      $display("tests failed");
      $fatal(1, "Bad case file");
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////
  initial begin
    void'($urandom(32'heca7_5ba1));
    casesLoaded                  = 1'b0;
    modelFlags                   = '0;
    reset                        = 1'b1;
    HoldEnable                   = 1'b0;
    HoldDelay                    = '0;
    HoldTime                     = HOLD_TIME_W'(1);
    ExternalRazSignalEnable      = 1'b0;
    ExternalRazDelayTime         = '0;
    RazMode                      = raz75ns;
    SlowControlOrReadScopeSelect = 1'b0;
    ResetB                       = '0;
    DataTriggerEnable            = 1'b0;
    EndReadoutParameter          = '0;
    PwrOnA                       = '0;
    PwrOnD                       = '0;
    PwrOnAdc                     = '0;
    PwrOnDac                     = '0;
    releaseTriggers();
    loadCases();
    casesLoaded = 1'b1;
    repeat (2) @(posedge Clk);
    @(negedge Clk);
    reset = 1'b0;
    // Idle values after reset
    checkBit("HoldSignal", 1'b0, HoldSignal);
    checkBit("RazChn", 1'b0, RazChn);
    checkBit("TrigExt", 1'b0, TrigExt);
    checkBit("RamReadoutDone", 1'b0, RamReadoutDone);
    checkBit("rstCounterB", 1'b1, rstCounterB);
    for (int i = 0; i < caseKinds.size(); i++) begin
      @(negedge Clk);
      runCase(caseKinds[i], caseOps[i]);
      repeat (4) @(negedge Clk);  // Let every block settle idle
    end
    $display("all tests passed");
    $finish;
  end

endmodule

// ==== hdl/externalRazGenerate.sv ====
module externalRazGenerate (
  input  logic                                   Clk,
  input  logic                                   reset,
  input  logic                                   TriggerIn,          // Trigger OR of the chain
  input  logic                                   ExternalRazEnable,
  input  logic [microrocCtrlPkg::RAZ_DELAY_W-1:0] ExternalRazDelayTime,
  input  microrocCtrlPkg::razMode_t              RazMode,
  input  logic                                   forceRaz,           // Bypasses enable and delay
  output logic                                   RazChn
);
  import microrocCtrlPkg::*;

  razState_t              razState;
  logic [RAZ_WIDTH_W-1:0] razCount;
  logic                   trigPrev;
  logic                   forcePrev;
  logic                   trigEdge;
  logic                   forceEdge;

  assign trigEdge  = TriggerIn & ~trigPrev;
  assign forceEdge = forceRaz & ~forcePrev;

  //////////////////////////////////////////////////////////////////////
  // RAZ request handling
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge Clk) begin
    if (reset) begin
      razState  <= razIdle;
      razCount  <= '0;
      trigPrev  <= 1'b0;
      forcePrev <= 1'b0;
      RazChn    <= 1'b0;
    end else begin
      trigPrev  <= TriggerIn;
      forcePrev <= forceRaz;
      case (razState)
        razIdle: begin
          // Forced request wins and skips the programmed delay
          if (forceEdge) begin
            razState <= razWait;
            razCount <= '0;
          end else if (trigEdge && ExternalRazEnable) begin
            razState <= razWait;
            razCount <= RAZ_WIDTH_W'(ExternalRazDelayTime);
          end
        end
        razWait: begin
          if (razCount == '0) begin
            razState <= razPulse;
            RazChn   <= 1'b1;
            razCount <= RAZ_WIDTH_TABLE[RazMode] - RAZ_WIDTH_W'(1);  // Mode latched here
          end else begin
            razCount <= razCount - RAZ_WIDTH_W'(1);
          end
        end
        razPulse: begin
          if (razCount == '0) begin
            razState <= razIdle;
            RazChn   <= 1'b0;
          end else begin
            razCount <= razCount - RAZ_WIDTH_W'(1);
          end
        end
        default: razState <= razIdle;
      endcase
    end
  end

  // Pulse only leaves the block through the pulse state
  razIdleQuiet: assert property (@(posedge Clk) disable iff (reset)
    (razState == razIdle) |-> !RazChn)
    else $error("RazChn high while RAZ sequencer idle");

endmodule

// ==== hdl/holdGenerate.sv ====
module holdGenerate (
  input  logic                                    Clk,
  input  logic                                    reset,
  input  logic                                    TriggerIn,
  input  logic                                    HoldEnable,
  input  logic [microrocCtrlPkg::HOLD_DELAY_W-1:0] HoldDelay,
  input  logic [microrocCtrlPkg::HOLD_TIME_W-1:0]  HoldTime,   // At least 1
  output logic                                    HoldSignal,
  output logic                                    holdForceRaz
);
  import microrocCtrlPkg::*;

  holdState_t             holdState;
  logic [HOLD_TIME_W-1:0] holdCount;   // Shared by delay and width phases
  logic                   trigPrev;
  logic                   trigEdge;
  logic [HOLD_TIME_W-1:0] highCycles;  // Length of the current hold

  assign trigEdge = TriggerIn & ~trigPrev;

  //////////////////////////////////////////////////////////////////////
  // Delay then width sequencer
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge Clk) begin
    if (reset) begin
      holdState    <= holdIdle;
      holdCount    <= '0;
      trigPrev     <= 1'b0;
      HoldSignal   <= 1'b0;
      holdForceRaz <= 1'b0;
    end else begin
      trigPrev     <= TriggerIn;
      holdForceRaz <= 1'b0;  // Single-cycle strobe
      case (holdState)
        holdIdle: begin
          if (trigEdge && HoldEnable) begin
            holdState <= holdDelay;
            holdCount <= HOLD_TIME_W'(HoldDelay);  // Zero-extended delay
          end
        end
        holdDelay: begin
          if (holdCount == '0) begin
            holdState  <= holdActive;
            HoldSignal <= 1'b1;
            holdCount  <= HoldTime - HOLD_TIME_W'(1);
          end else begin
            holdCount <= holdCount - HOLD_TIME_W'(1);
          end
        end
        holdActive: begin
          if (holdCount == '0) begin
            holdState    <= holdIdle;
            HoldSignal   <= 1'b0;
            holdForceRaz <= 1'b1;  // Analog reset follows every hold
          end else begin
            holdCount <= holdCount - HOLD_TIME_W'(1);
          end
        end
        default: holdState <= holdIdle;
      endcase
    end
  end

  // Counts cycles spent with hold asserted
  always_ff @(posedge Clk) begin
    if (reset || !HoldSignal) begin
      highCycles <= '0;
    end else begin
      highCycles <= highCycles + HOLD_TIME_W'(1);
    end
  end

  holdWidthBound: assert property (@(posedge Clk) disable iff (reset)
    HoldSignal |-> (highCycles < HoldTime))
    else $error("HoldSignal held longer than HoldTime");

endmodule

// ==== hdl/microrocCommonControl.sv ====
module microrocCommonControl #(
  parameter int chainCount = 4
) (
  input  logic                                    Clk,
  input  logic                                    reset,
  input  logic                                    TriggerIn,
  input  logic                                    TriggerOr,
  // Hold
  input  logic                                    HoldEnable,
  input  logic [microrocCtrlPkg::HOLD_DELAY_W-1:0] HoldDelay,
  input  logic [microrocCtrlPkg::HOLD_TIME_W-1:0]  HoldTime,
  output logic                                    HoldSignal,
  // External RAZ
  input  logic                                    ExternalRazSignalEnable,
  input  logic [microrocCtrlPkg::RAZ_DELAY_W-1:0]  ExternalRazDelayTime,
  input  microrocCtrlPkg::razMode_t               RazMode,
  input  logic [chainCount-1:0]                   ForceExternalRaz,
  output logic                                    RazChn,
  // 1 selects slow control register, 0 read register
  input  logic                                    SlowControlOrReadScopeSelect,
  output logic                                    Select,
  input  logic [chainCount-1:0]                   ResetB,
  output logic                                    AsicResetB,
  // Timestamp and external trigger
  input  logic                                    ResetTimeStamp,
  input  logic                                    DataTrigger,
  input  logic                                    DataTriggerEnable,
  output logic                                    rstCounterB,
  output logic                                    TrigExt,
  // Readout completion
  input  logic [chainCount-1:0]                   OnceEnd,
  input  logic [chainCount-1:0]                   EndReadoutParameter,
  output logic                                    RamReadoutDone,
  // Power pulsing enables
  input  logic [chainCount-1:0]                   PwrOnA,
  input  logic [chainCount-1:0]                   PwrOnD,
  input  logic [chainCount-1:0]                   PwrOnAdc,
  input  logic [chainCount-1:0]                   PwrOnDac,
  output logic                                    PwrOnAOut,
  output logic                                    PwrOnDOut,
  output logic                                    PwrOnAdcOut,
  output logic                                    PwrOnDacOut
);

  logic holdForceRaz;  // End of hold
  logic forceRaz;

  assign forceRaz = (|ForceExternalRaz) | holdForceRaz;  // Any chain or the hold

  holdGenerate u_holdGenerate (
    .Clk          (Clk),
    .reset        (reset),
    .TriggerIn    (TriggerIn),
    .HoldEnable   (HoldEnable),
    .HoldDelay    (HoldDelay),
    .HoldTime     (HoldTime),
    .HoldSignal   (HoldSignal),
    .holdForceRaz (holdForceRaz)
  );

  externalRazGenerate u_externalRazGenerate (
    .Clk                  (Clk),
    .reset                (reset),
    .TriggerIn            (TriggerOr),
    .ExternalRazEnable    (ExternalRazSignalEnable),
    .ExternalRazDelayTime (ExternalRazDelayTime),
    .RazMode              (RazMode),
    .forceRaz             (forceRaz),
    .RazChn               (RazChn)
  );

  timeStampSync u_timeStampSync (
    .Clk               (Clk),
    .reset             (reset),
    .ResetTimeStamp    (ResetTimeStamp),
    .DataTrigger       (DataTrigger),
    .DataTriggerEnable (DataTriggerEnable),
    .rstCounterB       (rstCounterB),
    .TrigExt           (TrigExt)
  );

  readoutDoneDetect #(
    .chainCount (chainCount)
  ) u_readoutDoneDetect (
    .Clk                 (Clk),
    .reset               (reset),
    .OnceEnd             (OnceEnd),
    .EndReadoutParameter (EndReadoutParameter),
    .RamReadoutDone      (RamReadoutDone)
  );

  //////////////////////////////////////////////////////////////////////
  // Chain-wide static controls
  //////////////////////////////////////////////////////////////////////
  assign Select      = ~SlowControlOrReadScopeSelect;  // ASIC pin is inverted
  assign AsicResetB  = |ResetB;
  assign PwrOnAOut   = |PwrOnA;    // Analog
  assign PwrOnDOut   = |PwrOnD;    // Digital
  assign PwrOnAdcOut = |PwrOnAdc;
  assign PwrOnDacOut = |PwrOnDac;

endmodule

// ==== hdl/microrocCtrlPkg.sv ====
package microrocCtrlPkg;

  //////////////////////////////////////////////////////////////////////
  // Configuration field widths
  //////////////////////////////////////////////////////////////////////
  localparam int HOLD_DELAY_W = 8;   // Trigger to hold, in Clk cycles
  localparam int HOLD_TIME_W  = 16;  // Hold width, in Clk cycles
  localparam int RAZ_DELAY_W  = 4;   // Trigger OR to RAZ, in Clk cycles
  localparam int RAZ_WIDTH_W  = 6;   // Holds the widest RAZ entry

  // Cycles of active-low timestamp counter reset
  localparam int TS_RESET_CYCLES = 8;

  //////////////////////////////////////////////////////////////////////
  // RAZ pulse width selection
  //////////////////////////////////////////////////////////////////////
  typedef enum logic [1:0] {
    raz75ns  = 2'd0,
    raz250ns = 2'd1,
    raz500ns = 2'd2,
    raz1us   = 2'd3
  } razMode_t;

  // Widths at 40 MHz, indexed by razMode_t
  localparam logic [RAZ_WIDTH_W-1:0] RAZ_WIDTH_TABLE [4] = '{6'd3, 6'd10, 6'd20, 6'd40};

  // Hold pulse sequencer
  typedef enum logic [1:0] {holdIdle, holdDelay, holdActive} holdState_t;

  // External RAZ sequencer
  typedef enum logic [1:0] {razIdle, razWait, razPulse} razState_t;

endpackage

// ==== hdl/readoutDoneDetect.sv ====
module readoutDoneDetect #(
  parameter int chainCount = 4
) (
  input  logic                  Clk,
  input  logic                  reset,
  input  logic [chainCount-1:0] OnceEnd,              // Per-chain end of RAM readout
  input  logic [chainCount-1:0] EndReadoutParameter,  // Chains taking part
  output logic                  RamReadoutDone
);

  logic [chainCount-1:0] onceEndPrev;
  logic [chainCount-1:0] onceEndRise;
  logic [chainCount-1:0] endFlags;     // Sticky, one per chain
  logic                  allDone;

  assign onceEndRise = OnceEnd & ~onceEndPrev;

  // Every participating chain finished, empty mask never counts
  assign allDone = (|EndReadoutParameter) &&
                   ((endFlags & EndReadoutParameter) == EndReadoutParameter);

  //////////////////////////////////////////////////////////////////////
  // Flag collection and done pulse
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge Clk) begin
    if (reset) begin
      onceEndPrev    <= '0;
      endFlags       <= '0;
      RamReadoutDone <= 1'b0;
    end else begin
      onceEndPrev    <= OnceEnd;
      RamReadoutDone <= allDone;
      if (allDone) begin
        endFlags <= onceEndRise;  // Fresh round, keep any new end
      end else begin
        endFlags <= endFlags | onceEndRise;
      end
    end
  end

  doneNeedsMask: assert property (@(posedge Clk) disable iff (reset)
    RamReadoutDone |-> $past(|EndReadoutParameter))
    else $error("RamReadoutDone raised with empty chain mask");

endmodule

// ==== hdl/timeStampSync.sv ====
module timeStampSync (
  input  logic Clk,
  input  logic reset,
  input  logic ResetTimeStamp,
  input  logic DataTrigger,
  input  logic DataTriggerEnable,
  output logic rstCounterB,      // Active low
  output logic TrigExt
);
  import microrocCtrlPkg::*;

  logic       rtsPrev;
  logic       dtPrev;
  logic       rtsEdge;
  logic       dtEdge;
  logic       dtHit;         // Gated trigger, one stage before output
  logic [3:0] stretchCount;  // Remaining counter reset cycles

  assign rtsEdge = ResetTimeStamp & ~rtsPrev;
  assign dtEdge  = DataTrigger & ~dtPrev;

  always_ff @(posedge Clk) begin
    if (reset) begin
      rtsPrev      <= 1'b0;
      dtPrev       <= 1'b0;
      stretchCount <= '0;
      rstCounterB  <= 1'b1;  // Counter runs after reset
      dtHit        <= 1'b0;
      TrigExt      <= 1'b0;
    end else begin
      rtsPrev <= ResetTimeStamp;
      dtPrev  <= DataTrigger;
      // New request restarts the stretch
      if (rtsEdge) begin
        stretchCount <= 4'(TS_RESET_CYCLES);
      end else if (stretchCount != '0) begin
        stretchCount <= stretchCount - 4'd1;
      end
      rstCounterB <= (stretchCount == '0);
      dtHit       <= dtEdge & DataTriggerEnable;  // Enable sampled with the edge
      TrigExt     <= dtHit;
    end
  end

  trigExtSingle: assert property (@(posedge Clk) disable iff (reset)
    TrigExt |=> !TrigExt)
    else $error("TrigExt wider than one cycle");

endmodule

// ==== microrocCommonControl.f ====
hdl/microrocCtrlPkg.sv
hdl/holdGenerate.sv
hdl/externalRazGenerate.sv
hdl/timeStampSync.sv
hdl/readoutDoneDetect.sv
hdl/microrocCommonControl.sv
dv/microrocCommonControlTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the MICROROC common control testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 \
  --top-module microrocCommonControlTb \
  -f microrocCommonControl.f -o microrocSim &&
./obj_dir/microrocSim 2>&1 | tee /dev/stderr | grep -q "^all tests passed$" &&
echo "Simulation PASS" ||
{ echo "Simulation FAIL"; exit 1; }
